// File: rtl/lenet_pkg.sv
`default_nettype none

package lenet_pkg;

    localparam int unsigned ACT_W    = 8;
    localparam int unsigned WEIGHT_W = 8;
    localparam int unsigned PROD_W   = 16;
    localparam int unsigned SHIFT_W  = 5;
    localparam int unsigned PIX_W    = 8;

    // wide enough for 256 taps of full-scale products.
    localparam int unsigned ACC_W    = 24;

    typedef logic [ACT_W-1:0]    act_t;
    typedef logic [WEIGHT_W-1:0] weight_t;
    typedef logic [PROD_W-1:0]   prod_t;
    typedef logic [ACC_W-1:0]    acc_t;
    typedef logic [SHIFT_W-1:0]  shift_t;
    typedef logic [PIX_W-1:0]    pix_t;

    // LANE_HOLD means a finished window sum waits for the requantizer.
    typedef enum logic {
        LANE_ACCUM = 1'b0,
        LANE_HOLD  = 1'b1
    } lane_state_e;

endpackage

`default_nettype wire

// File: rtl/mac_stream_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mac_stream_if;
    import lenet_pkg::*;

    logic    valid;
    logic    ready;
    act_t    act;
    weight_t weight;
    logic    last;  // closes the window.

    modport src (
        output valid, act, weight, last,
        input  ready
    );

    modport snk (
        input  valid, act, weight, last,
        output ready
    );

endinterface

`default_nettype wire

// File: rtl/lenet_approx_mul.sv
`timescale 1ns/10ps
`default_nettype none

module lenet_approx_mul (
    input  lenet_pkg::act_t    a,
    input  lenet_pkg::weight_t b,
    output lenet_pkg::prod_t   p
);
    import lenet_pkg::*;

    weight_t     pp [8];
    logic [12:0] c1;
    logic [12:0] c2;
    logic [12:0] c3;
    logic [12:0] c4;
    logic [12:0] c5;
    prod_t       row6;
    prod_t       row7;

    for (genvar i = 0; i < 8; i++) begin : g_rows
        assign pp[i] = b & {8{a[i]}};  // one row per activation bit.
    end

    // the lower six rows are folded pairwise into five sparse vectors.
    always_comb begin
        c1     = '0;
        c1[4]  = pp[0][4] | pp[1][3];
        c1[5]  = pp[0][4] ^ pp[1][3];
        c1[6]  = pp[0][5] | pp[1][4];
        c1[7]  = pp[2][5] ^ pp[3][4];
        c1[8]  = pp[0][7] ^ pp[1][6];
        c1[9]  = pp[2][6] & pp[3][5];
        c1[10] = pp[2][7] & pp[3][6];
        c1[11] = pp[4][7] & pp[5][6];
        c1[12] = pp[5][7];
    end

    always_comb begin
        c2     = '0;
        c2[5]  = pp[4][1] & pp[5][0];
        c2[6]  = pp[2][3] & pp[3][2];
        c2[7]  = pp[4][2] | pp[5][1];
        c2[8]  = pp[1][7];
        c2[9]  = pp[2][7] ^ pp[3][6];
        c2[10] = pp[3][7];
        c2[11] = pp[4][7] | pp[5][6];
    end

    always_comb begin
        c3     = '0;
        c3[5]  = pp[4][1] ^ pp[5][0];
        c3[7]  = pp[4][3] | pp[5][2];
        c3[8]  = pp[2][6] | pp[3][5];
        c3[9]  = pp[4][5] & pp[5][4];
        c3[10] = pp[4][6] & pp[5][5];
    end

    always_comb begin
        c4     = '0;
        c4[8]  = pp[4][4] & pp[5][3];
        c4[9]  = pp[4][5] | pp[5][4];
        c4[10] = pp[4][6] | pp[5][5];
    end

    always_comb begin
        c5     = '0;
        c5[8]  = pp[4][4] | pp[5][3];
    end

    // the two top rows stay exact.
    assign row6 = {2'b00, pp[6], 6'b000000};
    assign row7 = {1'b0, pp[7], 7'b0000000};

    assign p = row6 + row7
             + {3'b000, c1}
             + {3'b000, c2}
             + {3'b000, c3}
             + {3'b000, c4}
             + {3'b000, c5};

endmodule

`default_nettype wire

// File: rtl/lenet_mac_lane.sv
`timescale 1ns/10ps
`default_nettype none

module lenet_mac_lane #(
    parameter int unsigned ACC_W = lenet_pkg::ACC_W
) (
    input  logic            clk,
    input  logic            arst_n,
    mac_stream_if.snk       in_s,
    output logic            sum_valid,
    output lenet_pkg::acc_t sum,
    input  logic            sum_ready
);
    import lenet_pkg::*;

    prod_t            mul_p;
    logic             p1_valid;
    prod_t            p1_prod;
    logic             p1_last;
    logic             hold_busy;
    logic             s2_advance;
    logic [ACC_W-1:0] acc_q;
    logic [ACC_W-1:0] acc_next;
    logic [ACC_W-1:0] hold_q;
    lane_state_e      state_q;

    if (ACC_W != $bits(acc_t)) begin : g_acc_w_check
        $error("ACC_W differs from the package accumulator width.");
    end

    lenet_approx_mul i_mul (
        .a (in_s.act),
        .b (in_s.weight),
        .p (mul_p)
    );

    assign hold_busy  = (state_q == LANE_HOLD) && !sum_ready;
    assign s2_advance = p1_valid && !(p1_last && hold_busy);  // a last product needs a free hold.
    assign in_s.ready = !p1_valid || s2_advance;
    assign acc_next   = acc_q + ACC_W'(p1_prod);
    assign sum_valid  = (state_q == LANE_HOLD);
    assign sum        = hold_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            p1_valid <= 1'b0;
        end else if (in_s.ready) begin
            p1_valid <= in_s.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_s.valid && in_s.ready) begin
            p1_prod <= mul_p;
            p1_last <= in_s.last;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_q   <= '0;
            state_q <= LANE_ACCUM;
        end else begin
            if (s2_advance) begin
                acc_q <= p1_last ? '0 : acc_next;  // next window starts from zero.
            end
            if (s2_advance && p1_last) begin
                state_q <= LANE_HOLD;
            end else if (sum_ready) begin
                state_q <= LANE_ACCUM;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s2_advance && p1_last) begin
            hold_q <= acc_next;
        end
    end

    a_beat_known: assert property (@(posedge clk) disable iff (!arst_n)
        (in_s.valid && in_s.ready) |-> !$isunknown({in_s.act, in_s.weight, in_s.last}));

    a_sum_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (sum_valid && !sum_ready) |=> (sum_valid && $stable(sum)));

endmodule

`default_nettype wire

// File: rtl/lenet_requant.sv
`timescale 1ns/10ps
`default_nettype none

module lenet_requant (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              sum_valid,
    input  lenet_pkg::acc_t   sum,
    output logic              sum_ready,
    input  lenet_pkg::shift_t out_shift,
    output logic              out_valid,
    output lenet_pkg::pix_t   out_pix,
    input  logic              out_ready
);
    import lenet_pkg::*;

    acc_t shifted;
    pix_t sat_pix;

    assign shifted = sum >> out_shift;

    // anything left above the low byte clips to full scale.
    assign sat_pix = (|shifted[ACC_W-1:PIX_W]) ? '1 : shifted[PIX_W-1:0];

    // a new sum may enter in the same cycle the current pixel leaves.
    assign sum_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (sum_ready) begin
            out_valid <= sum_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sum_valid && sum_ready) begin
            out_pix <= sat_pix;
        end
    end

    a_pix_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_pix)));

endmodule

`default_nettype wire

// File: rtl/lenet_conv_unit.sv
`timescale 1ns/10ps
`default_nettype none

module lenet_conv_unit #(
    parameter int unsigned ACC_W = lenet_pkg::ACC_W
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_valid,
    input  lenet_pkg::act_t    in_act,
    input  lenet_pkg::weight_t in_weight,
    output logic               in_ready,
    input  logic               in_last,
    input  lenet_pkg::shift_t  out_shift,
    output logic               out_valid,
    output lenet_pkg::pix_t    out_pix,
    input  logic               out_ready
);
    import lenet_pkg::*;

    acc_t sum;
    logic sum_valid;
    logic sum_ready;

    mac_stream_if in_if ();

    assign in_if.valid  = in_valid;
    assign in_if.act    = in_act;
    assign in_if.weight = in_weight;
    assign in_if.last   = in_last;
    assign in_ready     = in_if.ready;

    lenet_mac_lane #(
        .ACC_W (ACC_W)
    ) i_lane (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_s      (in_if),
        .sum_valid (sum_valid),
        .sum       (sum),
        .sum_ready (sum_ready)
    );

    lenet_requant i_requant (
        .clk       (clk),
        .arst_n    (arst_n),
        .sum_valid (sum_valid),
        .sum       (sum),
        .sum_ready (sum_ready),
        .out_shift (out_shift),
        .out_valid (out_valid),
        .out_pix   (out_pix),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

// File: verification/tb_lenet_conv_unit.sv
`timescale 1ns/10ps
`default_nettype none

module tb_lenet_conv_unit;
    import lenet_pkg::*;

    localparam int unsigned SEED = 32'h086e471e;
    localparam int N_SINGLE = 16;
    localparam int N_K5     = 8;
    localparam int N_BP     = 10;
    localparam int TAPS     = 25;  // one 5x5 kernel.
    localparam int LAT_TAPS = 9;
    localparam int TOTAL_BEATS = 2 * N_SINGLE + 3 + N_K5 * TAPS + TAPS
                               + N_BP * TAPS + LAT_TAPS;
    localparam int CYCLE_LIMIT = TOTAL_BEATS * 4 + 200;

    logic    clk;
    logic    arst_n;
    logic    in_valid;
    act_t    in_act;
    weight_t in_weight;
    logic    in_ready;
    logic    in_last;
    shift_t  out_shift;
    logic    out_valid;
    pix_t    out_pix;
    logic    out_ready;

    int      cycle = 0;
    int      last_accept_cycle;
    int      out_cycle;
    int      windows_sent = 0;
    int      results = 0;
    pix_t    last_pix;
    pix_t    exp_q[$];
    act_t    win_act[$];
    weight_t win_wt[$];
    string   test_name;

    lenet_conv_unit #(
        .ACC_W (ACC_W)
    ) i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_act    (in_act),
        .in_weight (in_weight),
        .in_ready  (in_ready),
        .in_last   (in_last),
        .out_shift (out_shift),
        .out_valid (out_valid),
        .out_pix   (out_pix),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "%s", why);
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            abort_run($sformatf("timeout after %0d cycles, the DUT stopped responding", cycle));
        end
    end

    // the top two rows stay exact and the lower six are folded bit by bit.
    function automatic prod_t approx_mul_model(input act_t a, input weight_t b);
        logic [7:0]  r [8];
        int unsigned total;
        for (int i = 0; i < 8; i++) begin
            r[i] = a[i] ? b : 8'h00;
        end
        total = (r[6] << 6) + (r[7] << 7)
              + ((r[0][4] | r[1][3]) << 4) + ((r[0][4] ^ r[1][3]) << 5)
              + ((r[0][5] | r[1][4]) << 6) + ((r[2][5] ^ r[3][4]) << 7)
              + ((r[0][7] ^ r[1][6]) << 8) + ((r[2][6] & r[3][5]) << 9)
              + ((r[2][7] & r[3][6]) << 10) + ((r[4][7] & r[5][6]) << 11)
              + (r[5][7] << 12)
              + ((r[4][1] & r[5][0]) << 5) + ((r[2][3] & r[3][2]) << 6)
              + ((r[4][2] | r[5][1]) << 7) + (r[1][7] << 8)
              + ((r[2][7] ^ r[3][6]) << 9) + (r[3][7] << 10)
              + ((r[4][7] | r[5][6]) << 11)
              + ((r[4][1] ^ r[5][0]) << 5) + ((r[4][3] | r[5][2]) << 7)
              + ((r[2][6] | r[3][5]) << 8) + ((r[4][5] & r[5][4]) << 9)
              + ((r[4][6] & r[5][5]) << 10)
              + ((r[4][4] & r[5][3]) << 8) + ((r[4][5] | r[5][4]) << 9)
              + ((r[4][6] | r[5][5]) << 10)
              + ((r[4][4] | r[5][3]) << 8);
        return prod_t'(total);
    endfunction

    function automatic pix_t requant_model(input acc_t sum, input shift_t sh);
        acc_t v;
        v = sum >> sh;
        return (v > acc_t'(255)) ? pix_t'(255) : pix_t'(v);
    endfunction

    task automatic check_pix(input pix_t expected, input pix_t actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %0d, actual %0d", test_name, expected, actual);
            abort_run("output pixel mismatch");
        end
    endtask

    task automatic check_prod(input prod_t expected, input prod_t actual);
        if (actual !== expected) begin
            $display("ERR %s: expected 0x%04h, actual 0x%04h", test_name, expected, actual);
            abort_run("product mismatch");
        end
    endtask

    task automatic check_latency(input int expected, input int actual);
        if (actual != expected) begin
            $display("ERR %s: expected %0d, actual %0d", test_name, expected, actual);
            abort_run("output latency mismatch");
        end
    endtask

    // called 1 ns after an edge and returns 1 ns after the accepting edge.
    task automatic send_beat(input act_t a, input weight_t b, input logic last);
        in_valid  = 1'b1;
        in_act    = a;
        in_weight = b;
        in_last   = last;
        do begin
            @(posedge clk);
        end while (!in_ready);
        if (last) begin
            last_accept_cycle = cycle;
        end
        #1;
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic fill_random(input int taps);
        win_act.delete();
        win_wt.delete();
        for (int i = 0; i < taps; i++) begin
            win_act.push_back(act_t'($urandom));
            win_wt.push_back(weight_t'($urandom));
        end
    endtask

    task automatic send_window(input shift_t sh, input int gap_max);
        acc_t sum;
        int   gap;
        sum = '0;
        foreach (win_act[i]) begin
            sum += acc_t'(approx_mul_model(win_act[i], win_wt[i]));
        end
        exp_q.push_back(requant_model(sum, sh));
        windows_sent++;
        out_shift = sh;
        foreach (win_act[i]) begin
            gap = $urandom_range(0, gap_max);
            if (gap > 0) begin
                repeat (gap) @(posedge clk);
                #1;
            end
            send_beat(win_act[i], win_wt[i], i == win_act.size() - 1);
        end
    endtask

    task automatic collect_pixels(input int count, input logic random_ready,
                                  input logic check_it);
        int n;
        n = 0;
        while (n < count) begin
            @(posedge clk);
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    abort_run("a pixel arrived with no window pending");
                end else begin
                    last_pix  = out_pix;
                    out_cycle = cycle;
                    if (check_it) begin
                        check_pix(exp_q.pop_front(), out_pix);
                    end else begin
                        void'(exp_q.pop_front());  // the caller checks this pixel itself.
                    end
                    results++;
                    n++;
                end
            end
            #1;
            out_ready = random_ready ? 1'($urandom_range(0, 1)) : 1'b1;
        end
    endtask

    task automatic run_single(input act_t a, input weight_t b, input shift_t sh,
                              input logic check_it);
        win_act.delete();
        win_wt.delete();
        win_act.push_back(a);
        win_wt.push_back(b);
        send_window(sh, 0);
        collect_pixels(1, 1'b0, check_it);
    endtask

    initial begin
        act_t    a;
        weight_t b;
        prod_t   mp;
        void'($urandom(SEED));
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_act    = '0;
        in_weight = '0;
        in_last   = 1'b0;
        out_shift = '0;
        out_ready = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        if (!in_ready || out_valid) begin
            abort_run("handshake outputs are wrong after reset");
        end

        test_name = "single_tap";
        for (int i = 0; i < N_SINGLE; i++) begin
            a  = act_t'($urandom);
            b  = weight_t'($urandom);
            mp = approx_mul_model(a, b);
            run_single(a, b, 5'd0, 1'b1);
            run_single(a, b, 5'd8, 1'b0);  // leaves the high byte of the product.
            check_prod({mp[15:8], 8'h00}, {last_pix, 8'h00});
        end

        test_name = "corners";
        a = act_t'($urandom);
        b = weight_t'($urandom);
        run_single(8'd0, b, 5'd0, 1'b1);
        check_pix(8'd0, last_pix);
        run_single(a, 8'd0, 5'd0, 1'b1);
        check_pix(8'd0, last_pix);
        run_single(8'd1, 8'd1, 5'd0, 1'b1);

        test_name = "kernel_5x5";
        for (int i = 0; i < N_K5; i++) begin
            fill_random(TAPS);
            send_window(shift_t'($urandom_range(6, 14)), 0);
            collect_pixels(1, 1'b0, 1'b1);
        end

        test_name = "saturation";
        win_act.delete();
        win_wt.delete();
        for (int i = 0; i < TAPS; i++) begin
            win_act.push_back(8'hff);
            win_wt.push_back(8'hff);
        end
        send_window(5'd2, 0);
        collect_pixels(1, 1'b0, 1'b1);
        check_pix(8'hff, last_pix);

        test_name = "back_pressure";
        fork
            begin
                for (int i = 0; i < N_BP; i++) begin
                    fill_random(TAPS);
                    send_window(5'd10, 2);
                end
            end
            collect_pixels(N_BP, 1'b1, 1'b1);
        join
        out_ready = 1'b1;
        repeat (10) begin
            @(posedge clk);
            if (out_valid) begin
                abort_run("an extra pixel appeared after all windows drained");
            end
        end
        #1;

        test_name = "latency";
        fill_random(LAT_TAPS);
        send_window(5'd8, 0);
        collect_pixels(1, 1'b0, 1'b1);
        check_latency(3, out_cycle - last_accept_cycle);

        if (results == windows_sent && exp_q.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            abort_run("the number of pixels differs from the number of windows sent");
        end
    end

endmodule

`default_nettype wire

// File: sources.f
rtl/lenet_pkg.sv
rtl/mac_stream_if.sv
rtl/lenet_approx_mul.sv
rtl/lenet_mac_lane.sv
rtl/lenet_requant.sv
rtl/lenet_conv_unit.sv
verification/tb_lenet_conv_unit.sv

// File: Bender.yml
package:
  name: lenet_conv_unit

sources:
  - rtl/lenet_pkg.sv
  - rtl/mac_stream_if.sv
  - rtl/lenet_approx_mul.sv
  - rtl/lenet_mac_lane.sv
  - rtl/lenet_requant.sv
  - rtl/lenet_conv_unit.sv
  - target: test
    files:
      - verification/tb_lenet_conv_unit.sv
